// ==== verilog/rename_pkg.sv ====
package rename_pkg;

    // Register file geometry
    localparam int lreg_w    = 5;
    localparam int preg_w    = 6;
    localparam int num_lregs = 32;
    localparam int num_pregs = 64;

    typedef logic [lreg_w-1:0] lreg_t;
    typedef logic [preg_w-1:0] preg_t;

    // One instruction presented for rename
    typedef struct packed {
        lreg_t lrs1;
        lreg_t lrs2;
        lreg_t lrd;
        logic  need_to_wb;
    } dispatch_t;

    // Rename result, old_prd is the mapping of lrd before this dispatch
    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        preg_t old_prd;
    } rename_t;

    // One retirement from the reorder buffer
    typedef struct packed {
        logic  valid;
        logic  need_to_wb;
        lreg_t lrd;
        preg_t prd;
        preg_t old_prd;
    } commit_t;

    // Whole logical to physical map, entry i belongs to logical register i
    typedef preg_t [num_lregs-1:0] arch_map_t;

    typedef enum logic [1:0] {
        entry_free,
        entry_waiting,
        entry_done
    } entry_state_e;

endpackage

// ==== verilog/spec_rat.sv ====
`timescale 1ns/1ps

module spec_rat import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      dispatch_fire,
    input  dispatch_t dispatch,
    input  logic      flush,
    input  arch_map_t arch_map,
    input  preg_t     prd,
    output preg_t     prs1,
    output preg_t     prs2,
    output preg_t     old_prd
);

    ////////////////////////////////////////////////////////////
    // Speculative map
    ////////////////////////////////////////////////////////////

    arch_map_t map_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Identity map out of reset
            for (int i = 0; i < num_lregs; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (flush) begin
            // Throw away all speculative renames
            map_q <= arch_map;
        end else if (dispatch_fire && dispatch.need_to_wb) begin
            map_q[dispatch.lrd] <= prd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Rename lookup
    ////////////////////////////////////////////////////////////

    // Sources see the map before this dispatch writes it
    assign prs1    = map_q[dispatch.lrs1];
    assign prs2    = map_q[dispatch.lrs2];
    assign old_prd = map_q[dispatch.lrd];

endmodule

// ==== verilog/free_list.sv ====
`timescale 1ns/1ps

module free_list import rename_pkg::*; #(
    parameter  int rob_depth = 16,
    localparam int rb_w      = $clog2(rob_depth) + 1
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            dispatch_fire,
    input  logic            need_to_wb,
    output preg_t           head_preg,
    input  commit_t         commit0,
    input  commit_t         commit1,
    input  logic            flush,
    input  logic [rb_w-1:0] rollback_count
);

    localparam int ptr_w = lreg_w;
    localparam int cnt_w = lreg_w + 1;

    preg_t            queue [num_lregs];
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w-1:0] slot1;
    logic [cnt_w-1:0] free_count;
    logic             pop;
    logic             push0;
    logic             push1;

    assign pop   = dispatch_fire && need_to_wb;
    assign push0 = commit0.valid && commit0.need_to_wb;
    assign push1 = commit1.valid && commit1.need_to_wb;

    // Commit1 lands behind commit0 only when commit0 also returns a register
    assign slot1 = push0 ? tail + 1'b1 : tail;

    assign head_preg = queue[head];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Registers 32..63 start out free, in order
            for (int i = 0; i < num_lregs; i++) begin
                queue[i] <= preg_t'(num_lregs + i);
            end
            head       <= '0;
            tail       <= '0;
            free_count <= cnt_w'(num_lregs);
        end else if (flush) begin
            // Newest allocations sit just behind head, so stepping back frees them
            head       <= head - ptr_w'(rollback_count);
            free_count <= free_count + cnt_w'(rollback_count);
        end else begin
            if (push0) begin
                queue[tail] <= commit0.old_prd;
            end
            if (push1) begin
                queue[slot1] <= commit1.old_prd;
            end
            head       <= head + ptr_w'(pop);
            tail       <= tail + ptr_w'(push0) + ptr_w'(push1);
            free_count <= free_count + cnt_w'(push0) + cnt_w'(push1) - cnt_w'(pop);
        end
    end

    // In-flight bound of the reorder buffer keeps the queue from draining
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> free_count != '0)
        else $error("free_list: allocation from an empty free list");

endmodule

// ==== verilog/arch_rat.sv ====
`timescale 1ns/1ps

module arch_rat import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  commit_t   commit0,
    input  commit_t   commit1,
    output arch_map_t arch_map
);

    arch_map_t rat_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_lregs; i++) begin
                rat_q[i] <= preg_t'(i);
            end
        end else begin
            // Commit port 0
            if (commit0.valid && commit0.need_to_wb) begin
                rat_q[commit0.lrd] <= commit0.prd;
            end
            // Port 1 is younger, so it goes last and wins on the same lrd
            if (commit1.valid && commit1.need_to_wb) begin
                rat_q[commit1.lrd] <= commit1.prd;
            end
        end
    end

    assign arch_map = rat_q;

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; #(
    parameter  int rob_depth = 16,
    localparam int idx_w     = $clog2(rob_depth),
    localparam int cnt_w     = idx_w + 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  dispatch_t        dispatch,
    input  rename_t          rename,
    output logic             dispatch_ready,
    output logic             dispatch_fire,
    output logic [idx_w-1:0] dispatch_idx,
    input  logic             complete_valid,
    input  logic [idx_w-1:0] complete_idx,
    input  logic             flush,
    output commit_t          commit0,
    output commit_t          commit1,
    output logic [cnt_w-1:0] rollback_count
);

    // Payload kept per entry beside its state
    typedef struct packed {
        lreg_t lrd;
        logic  need_to_wb;
        preg_t prd;
        preg_t old_prd;
    } rob_entry_t;

    entry_state_e     state [rob_depth];
    rob_entry_t       entry [rob_depth];
    logic [idx_w-1:0] head;
    logic [idx_w-1:0] head_nxt;
    logic [idx_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic             retire0;
    logic             retire1;

    ////////////////////////////////////////////////////////////
    // Dispatch side
    ////////////////////////////////////////////////////////////

    assign dispatch_ready = count != cnt_w'(rob_depth);
    assign dispatch_fire  = dispatch_valid && dispatch_ready && !flush;
    assign dispatch_idx   = tail;

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            entry[tail] <= '{lrd:        dispatch.lrd,
                             need_to_wb: dispatch.need_to_wb,
                             prd:        rename.prd,
                             old_prd:    rename.old_prd};
        end
    end

    ////////////////////////////////////////////////////////////
    // Retire side
    ////////////////////////////////////////////////////////////

    assign head_nxt = head + 1'b1;
    // No commits leave in a flush cycle
    assign retire0  = !flush && (state[head] == entry_done);
    assign retire1  = retire0 && (state[head_nxt] == entry_done);

    assign commit0 = '{valid:      retire0,
                       need_to_wb: entry[head].need_to_wb,
                       lrd:        entry[head].lrd,
                       prd:        entry[head].prd,
                       old_prd:    entry[head].old_prd};
    assign commit1 = '{valid:      retire1,
                       need_to_wb: entry[head_nxt].need_to_wb,
                       lrd:        entry[head_nxt].lrd,
                       prd:        entry[head_nxt].prd,
                       old_prd:    entry[head_nxt].old_prd};

    // Live entries holding an allocated register are handed back on flush
    always_comb begin
        rollback_count = '0;
        for (int i = 0; i < rob_depth; i++) begin
            if (state[i] != entry_free && entry[i].need_to_wb) begin
                rollback_count = rollback_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rob_depth; i++) begin
                state[i] <= entry_free;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // Everything in flight is discarded
            for (int i = 0; i < rob_depth; i++) begin
                state[i] <= entry_free;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch_fire) begin
                state[tail] <= entry_waiting;
                tail        <= tail + 1'b1;
            end
            if (complete_valid) begin
                state[complete_idx] <= entry_done;
            end
            if (retire0) begin
                state[head] <= entry_free;
            end
            if (retire1) begin
                state[head_nxt] <= entry_free;
            end
            head  <= head + idx_w'(retire0) + idx_w'(retire1);
            count <= count + cnt_w'(dispatch_fire) - cnt_w'(retire0) - cnt_w'(retire1);
        end
    end

    a_complete_waiting: assert property (@(posedge clk) disable iff (reset)
        complete_valid && !flush |-> state[complete_idx] == entry_waiting)
        else $error("reorder_buffer: completion of entry %0d not waiting", complete_idx);

    // A pair of commits needs two live entries
    a_commit_pair: assert property (@(posedge clk) disable iff (reset)
        commit1.valid |-> count >= cnt_w'(2))
        else $error("reorder_buffer: commit1 valid with fewer than two live entries");

endmodule

// ==== verilog/rename_core.sv ====
`timescale 1ns/1ps

module rename_core import rename_pkg::*; #(
    parameter  int rob_depth = 16,
    localparam int rob_idx_w = $clog2(rob_depth),
    localparam int rob_cnt_w = rob_idx_w + 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  dispatch_t            dispatch,
    output logic                 dispatch_ready,
    output rename_t              rename,
    output logic [rob_idx_w-1:0] dispatch_idx,
    input  logic                 complete_valid,
    input  logic [rob_idx_w-1:0] complete_idx,
    input  logic                 flush,
    output commit_t              commit0,
    output commit_t              commit1,
    output arch_map_t            arch_map
);

    logic                 dispatch_fire;
    logic [rob_cnt_w-1:0] rollback_count;
    preg_t                prs1;
    preg_t                prs2;
    preg_t                old_prd;
    preg_t                head_preg;

    assign rename = '{prs1: prs1, prs2: prs2, prd: head_preg, old_prd: old_prd};

    // Rename lookup
    spec_rat u_spec_rat (
        .clk           (clk),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dispatch      (dispatch),
        .flush         (flush),
        .arch_map      (arch_map),
        .prd           (head_preg),
        .prs1          (prs1),
        .prs2          (prs2),
        .old_prd       (old_prd)
    );

    free_list #(.rob_depth(rob_depth)) u_free_list (
        .clk            (clk),
        .reset          (reset),
        .dispatch_fire  (dispatch_fire),
        .need_to_wb     (dispatch.need_to_wb),
        .head_preg      (head_preg),
        .commit0        (commit0),
        .commit1        (commit1),
        .flush          (flush),
        .rollback_count (rollback_count)
    );

    arch_rat u_arch_rat (
        .clk      (clk),
        .reset    (reset),
        .commit0  (commit0),
        .commit1  (commit1),
        .arch_map (arch_map)
    );

    reorder_buffer #(.rob_depth(rob_depth)) u_reorder_buffer (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .rename         (rename),
        .dispatch_ready (dispatch_ready),
        .dispatch_fire  (dispatch_fire),
        .dispatch_idx   (dispatch_idx),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .flush          (flush),
        .commit0        (commit0),
        .commit1        (commit1),
        .rollback_count (rollback_count)
    );

endmodule

// ==== test/tb_rename_core.sv ====
`timescale 1ns/1ps

module tb_rename_core import rename_pkg::*; ();

    localparam int rob_depth    = 16;
    localparam int idx_w        = $clog2(rob_depth);
    localparam int clk_period   = 100;
    localparam int drive_delay  = 10;
    localparam int reset_cycles = 16;
    localparam int drain_limit  = 64;
    // Cycle budget of each test including its drain
    localparam int boot_len     = 4;
    localparam int chain_len    = 12 + drain_limit;
    localparam int random_len   = 300 + drain_limit;
    localparam int wrap_len     = 160 + drain_limit;
    localparam int full_len     = 28 + drain_limit;
    localparam int flush_len    = 15 + drain_limit;
    localparam int watchdog_cycles = 2 * (reset_cycles + boot_len + chain_len
                                          + random_len + wrap_len + full_len + flush_len);

    // Model view of one in-flight instruction
    typedef struct packed {
        logic [idx_w-1:0] idx;
        logic             done;
        lreg_t            lrd;
        logic             wb;
        preg_t            prd;
        preg_t            old_prd;
    } rob_rec_t;

    logic             clk;
    logic             reset;
    logic             dispatch_valid;
    dispatch_t        dispatch;
    logic             dispatch_ready;
    rename_t          rename;
    logic [idx_w-1:0] dispatch_idx;
    logic             complete_valid;
    logic [idx_w-1:0] complete_idx;
    logic             flush;
    commit_t          commit0;
    commit_t          commit1;
    arch_map_t        arch_map;

    // Reference model state
    arch_map_t        m_spec;
    arch_map_t        m_arch;
    preg_t            m_free[$];
    rob_rec_t         m_rob[$];
    logic [idx_w-1:0] m_tail;

    // Expected outputs of the current cycle
    logic             exp_ready;
    logic [idx_w-1:0] exp_idx;
    rename_t          exp_rename;
    commit_t          exp_c0;
    commit_t          exp_c1;

    int err_count;
    int hang_count;
    int test_count;
    int test_start;

    rename_core #(.rob_depth(rob_depth)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the run is stuck", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic dispatch_t rand_dispatch(input int lrd_max, input int wb_pct);
        dispatch_t d;
        d.lrs1       = lreg_t'($urandom_range(num_lregs - 1));
        d.lrs2       = lreg_t'($urandom_range(num_lregs - 1));
        d.lrd        = lreg_t'($urandom_range(lrd_max));
        d.need_to_wb = int'($urandom_range(99)) < wb_pct;
        return d;
    endfunction

    function automatic commit_t to_commit(input rob_rec_t r);
        return '{valid: 1'b1, need_to_wb: r.wb, lrd: r.lrd, prd: r.prd, old_prd: r.old_prd};
    endfunction

    task automatic predict();
        exp_ready  = m_rob.size() < rob_depth;
        exp_idx    = m_tail;
        exp_rename = '{prs1: m_spec[dispatch.lrs1], prs2: m_spec[dispatch.lrs2],
                       prd: m_free[0], old_prd: m_spec[dispatch.lrd]};
        exp_c0 = '0;
        exp_c1 = '0;
        // Only done entries at the head leave, and none in a flush cycle
        if (!flush && m_rob.size() > 0 && m_rob[0].done) begin
            exp_c0 = to_commit(m_rob[0]);
            if (m_rob.size() > 1 && m_rob[1].done) begin
                exp_c1 = to_commit(m_rob[1]);
            end
        end
    endtask

    // Retiring entry writes the arch map and frees its stale register
    task automatic retire(input commit_t c);
        if (c.valid) begin
            void'(m_rob.pop_front());
            if (c.need_to_wb) begin
                m_arch[c.lrd] = c.prd;
                m_free.push_back(c.old_prd);
            end
        end
    endtask

    task automatic model_update();
        rob_rec_t rec;
        rob_rec_t hit;
        logic     fire;
        if (reset) begin
            m_free.delete();
            m_rob.delete();
            m_tail = '0;
            for (int i = 0; i < num_lregs; i++) begin
                m_spec[i] = preg_t'(i);
                m_arch[i] = preg_t'(i);
                m_free.push_back(preg_t'(num_lregs + i));
            end
        end else if (flush) begin
            // Oldest flushed allocation ends up at the front
            for (int i = m_rob.size() - 1; i >= 0; i--) begin
                if (m_rob[i].wb) begin
                    m_free.push_front(m_rob[i].prd);
                end
            end
            m_rob.delete();
            m_tail = '0;
            m_spec = m_arch;
        end else begin
            fire = dispatch_valid && m_rob.size() < rob_depth;
            rec  = '{idx: m_tail, done: 1'b0, lrd: dispatch.lrd, wb: dispatch.need_to_wb,
                     prd: m_free[0], old_prd: m_spec[dispatch.lrd]};
            retire(exp_c0);
            retire(exp_c1);
            if (complete_valid) begin
                foreach (m_rob[i]) begin
                    if (m_rob[i].idx == complete_idx) begin
                        hit      = m_rob[i];
                        hit.done = 1'b1;
                        m_rob[i] = hit;
                    end
                end
            end
            if (fire) begin
                if (rec.wb) begin
                    m_spec[rec.lrd] = rec.prd;
                    void'(m_free.pop_front());
                end
                m_rob.push_back(rec);
                m_tail++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // comp_mode 0 completes nothing, 1 a random waiting entry, 2 the oldest
    task automatic step(input logic dv, input dispatch_t d, input int comp_mode,
                        input logic fl);
        int waiting[$];
        int pick;
        @(posedge clk);
        model_update();
        #(drive_delay);
        dispatch_valid = dv;
        dispatch       = d;
        flush          = fl;
        complete_valid = 1'b0;
        if (comp_mode != 0 && !fl) begin
            foreach (m_rob[i]) begin
                if (!m_rob[i].done) begin
                    waiting.push_back(i);
                end
            end
            if (waiting.size() > 0) begin
                pick = (comp_mode == 1) ? waiting[$urandom_range(waiting.size() - 1)]
                                        : waiting[0];
                complete_valid = 1'b1;
                complete_idx   = m_rob[pick].idx;
            end
        end
        predict();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (m_rob.size() != 0 && n < drain_limit) begin
            step(1'b0, rand_dispatch(31, 50), 2, 1'b0);
            n++;
        end
    endtask

    task automatic begin_test();
        test_start = err_count + hang_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_count + hang_count - test_start;
        test_count++;
        $display("%s finished at %0t ns with %0d errors", name, $time, errs);
    endtask

    task automatic report_mismatch(input string name, input logic [191:0] expected,
                                   input logic [191:0] actual);
        err_count++;
        $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    ////////////////////////////////////////////////////////////
    // Output checks sampled mid cycle
    ////////////////////////////////////////////////////////////

    a_ready: assert property (@(negedge clk) disable iff (reset) dispatch_ready == exp_ready)
        else report_mismatch("dispatch_ready", 192'(exp_ready), 192'(dispatch_ready));
    a_idx: assert property (@(negedge clk) disable iff (reset) dispatch_idx == exp_idx)
        else report_mismatch("dispatch_idx", 192'(exp_idx), 192'(dispatch_idx));
    a_rename: assert property (@(negedge clk) disable iff (reset) rename == exp_rename)
        else report_mismatch("rename", 192'(exp_rename), 192'(rename));
    a_c0_valid: assert property (@(negedge clk) disable iff (reset)
        commit0.valid == exp_c0.valid)
        else report_mismatch("commit0.valid", 192'(exp_c0.valid), 192'(commit0.valid));
    a_c1_valid: assert property (@(negedge clk) disable iff (reset)
        commit1.valid == exp_c1.valid)
        else report_mismatch("commit1.valid", 192'(exp_c1.valid), 192'(commit1.valid));
    a_c0: assert property (@(negedge clk) disable iff (reset)
        exp_c0.valid |-> commit0 == exp_c0)
        else report_mismatch("commit0", 192'(exp_c0), 192'(commit0));
    a_c1: assert property (@(negedge clk) disable iff (reset)
        exp_c1.valid |-> commit1 == exp_c1)
        else report_mismatch("commit1", 192'(exp_c1), 192'(commit1));
    a_arch: assert property (@(negedge clk) disable iff (reset) arch_map == m_arch)
        else report_mismatch("arch_map", m_arch, arch_map);

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        dispatch_t d;
        int        waited;
        void'($urandom(32'h3513));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        complete_valid = 1'b0;
        complete_idx   = '0;
        flush          = 1'b0;
        hang_count     = 0;
        test_count     = 0;
        repeat (reset_cycles) step(1'b0, '0, 0, 1'b0);
        reset = 1'b0;

        begin_test();
        repeat (boot_len) step(1'b0, rand_dispatch(31, 100), 0, 1'b0);
        end_test("reset_state");

        // Same lrd twice in a row with lrs1 reading the last destination
        begin_test();
        for (int i = 0; i < 12; i++) begin
            d      = rand_dispatch(31, 100);
            d.lrd  = lreg_t'(4 + i / 2);
            d.lrs1 = d.lrd;
            step(1'b1, d, 0, 1'b0);
        end
        drain();
        end_test("rename_chain");

        // Small lrd range so paired commits often hit the same register
        begin_test();
        repeat (300) begin
            step(int'($urandom_range(99)) < 70, rand_dispatch(3, 85),
                 int'($urandom_range(99)) < 60 ? 1 : 0, 1'b0);
        end
        drain();
        end_test("random_retire");

        begin_test();
        repeat (160) step(1'b1, rand_dispatch(31, 100), 2, 1'b0);
        drain();
        end_test("free_list_wrap");

        begin_test();
        repeat (20) step(1'b1, rand_dispatch(31, 100), 0, 1'b0);
        waited = 0;
        do begin
            step(1'b0, rand_dispatch(31, 100), waited == 0 ? 2 : 0, 1'b0);
            @(negedge clk);
            waited++;
        end while (!dispatch_ready && waited < 8);
        if (!dispatch_ready) begin
            hang_count++;
            $display("dispatch_ready stayed low after a retirement");
        end
        drain();
        end_test("backpressure");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            step(1'b1, rand_dispatch(7, 100), (i % 3 == 2) ? 1 : 0, 1'b0);
        end
        step(1'b0, rand_dispatch(7, 100), 0, 1'b1);
        repeat (6) step(1'b1, rand_dispatch(7, 100), 0, 1'b0);
        drain();
        end_test("flush");

        // Let the last cycle be sampled
        #(clk_period);
        $display("Summary: %0d tests, %0d check errors, %0d stalls",
                 test_count, err_count, hang_count);
        if (err_count == 0 && hang_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/rename_pkg.sv
verilog/spec_rat.sv
verilog/free_list.sv
verilog/arch_rat.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
test/tb_rename_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rename subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_rename_core -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_rename_core)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
